//--- hdl/bch_channel_monitor.sv
`default_nettype none

`include "bch_params.svh"

module bch_channel_monitor (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire logic [`BCH_K-1:0] data_in,
	input wire logic [`BCH_N-1:0] error,
	input wire logic enc_busy,
	input wire logic code_bit,
	input wire logic code_valid,
	input wire logic key_done,
	input wire logic [1:0] key_count,
	input wire logic out_valid,
	input wire logic [`BCH_K-1:0] data_out,
	output logic ack,
	output logic enc_start,
	output logic [`BCH_K-1:0] enc_data,
	output logic rx_bit,
	output logic rx_valid,
	output logic wrong
);

	localparam int depth = `BCH_TRACK_DEPTH;
	localparam int ptr_w = $clog2(depth);

	logic [`BCH_N-1:0] err_shift;
	logic [3:0] count_q [depth];
	logic [`BCH_K-1:0] msg_q [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] cnt_ptr;
	logic [ptr_w-1:0] msg_ptr;
	logic [ptr_w:0] fill;
	logic [3:0] weight;
	logic accept;
	logic count_bad;
	logic data_bad;

	assign accept = req && !ack && !enc_busy && (fill != depth);
	assign rx_bit = code_bit ^ err_shift[0];
	assign rx_valid = code_valid;
	assign count_bad = key_done && ({2'b00, key_count} != count_q[cnt_ptr]);
	// beyond t errors the data is not expected to come back intact
	assign data_bad = out_valid && (count_q[msg_ptr] <= `BCH_T) && (data_out != msg_q[msg_ptr]);

	always_comb begin
		weight = '0;
		for (int i = 0; i < `BCH_N; i++)
			weight = weight + error[i];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			enc_start <= 1'b0;
			wr_ptr <= '0;
			cnt_ptr <= '0;
			msg_ptr <= '0;
			fill <= '0;
			wrong <= 1'b0;
		end else begin
			enc_start <= accept;
			if (accept)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
			if (accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (key_done)
				cnt_ptr <= cnt_ptr + 1'b1;
			if (out_valid)
				msg_ptr <= msg_ptr + 1'b1;
			if (accept && !out_valid)
				fill <= fill + 1'b1;
			else if (!accept && out_valid)
				fill <= fill - 1'b1;
			if (count_bad || data_bad)
				wrong <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			enc_data <= data_in;
			err_shift <= error;
			count_q[wr_ptr] <= weight;
			msg_q[wr_ptr] <= data_in;
		end else if (code_valid) begin
			err_shift <= err_shift >> 1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/bch_encode.sv
`default_nettype none

`include "bch_params.svh"

module bch_encode (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [`BCH_K-1:0] data,
	output logic busy,
	output logic code_bit,
	output logic code_valid
);

	import bch_pkg::*;

	localparam int par_w = `BCH_N - `BCH_K;
	// the x^10 term of g(x) is implied by the shift
	localparam logic [par_w-1:0] gen_taps = par_w'(`BCH_GEN);

	enc_state_t state;
	logic [3:0] count;
	logic [`BCH_K-1:0] msg;
	logic [par_w-1:0] lfsr;
	logic feedback;

	assign busy = (state != es_idle);
	assign code_valid = busy;
	assign feedback = msg[0] ^ lfsr[par_w-1];

	always_comb begin
		case (state)
			es_message: code_bit = msg[0];
			es_parity: code_bit = lfsr[par_w-1];
			default: code_bit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= es_idle;
			count <= '0;
		end else begin
			case (state)
				es_idle: begin
					count <= '0;
					if (start)
						state <= es_message;
				end
				es_message: begin
					count <= (count == `BCH_K - 1) ? '0 : count + 1'b1;
					if (count == `BCH_K - 1)
						state <= es_parity;
				end
				es_parity: begin
					count <= count + 1'b1;
					if (count == par_w - 1)
						state <= es_idle;
				end
				default: state <= es_idle;
			endcase
		end
	end

	// message enters low bit first, remainder leaves high bit first
	always_ff @(posedge clk) begin
		if (state == es_idle && start) begin
			msg <= data;
			lfsr <= '0;
		end else if (state == es_message) begin
			msg <= msg >> 1;
			lfsr <= {lfsr[par_w-2:0], 1'b0} ^ (gen_taps & {par_w{feedback}});
		end else if (state == es_parity) begin
			lfsr <= {lfsr[par_w-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- hdl/bch_error.sv
`default_nettype none

`include "bch_params.svh"

module bch_error (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire bch_pkg::key_result_t key,
	output logic busy,
	output logic [`BCH_K-1:0] data_out,
	output logic [1:0] err_count,
	output logic out_valid
);

	import bch_pkg::*;

	localparam gf_elem_t zero = 4'h0;
	// term j of sigma advances by alpha^j per position
	localparam gf_elem_t [`BCH_T:0] alpha_pow = {4'h8, 4'h4, 4'h2, 4'h1};

	chien_state_t state;
	logic [2:0] pos;
	gf_elem_t [`BCH_T:0] term;
	gf_elem_t [`BCH_T:0] term_init;
	gf_elem_t [`BCH_T:0] term_step;
	gf_elem_t eval;

	assign busy = (state == cs_search);

	always_comb begin
		eval = zero;
		for (int j = 0; j <= `BCH_T; j++) begin
			term_init[j] = gf_mul(key.sigma[j], alpha_pow[j]);
			term_step[j] = gf_mul(term[j], alpha_pow[j]);
			eval = eval ^ term[j];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cs_idle;
			pos <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				cs_idle: begin
					pos <= '0;
					if (start)
						state <= cs_search;
				end
				cs_search: begin
					pos <= pos + 1'b1;
					if (pos == `BCH_K) begin
						out_valid <= 1'b1;
						state <= cs_idle;
					end
				end
				default: state <= cs_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cs_idle && start) begin
			term <= term_init;
			data_out <= key.msg;
			err_count <= key.count;
		end else if (state == cs_search && pos < `BCH_K) begin
			term <= term_step;
			// a root at alpha^(pos+1) marks message bit pos
			if (eval == zero)
				data_out[pos] <= ~data_out[pos];
		end
	end

endmodule

`default_nettype wire

//--- hdl/bch_key.sv
`default_nettype none

`include "bch_params.svh"

module bch_key (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire bch_pkg::syn_result_t syn,
	input wire logic next_busy,
	output logic busy,
	output logic done,
	output bch_pkg::key_result_t result
);

	import bch_pkg::*;

	localparam gf_elem_t zero = 4'h0;
	localparam gf_elem_t one = 4'h1;

	key_state_t state;
	syn_result_t syn_q;
	gf_elem_t s2;
	gf_elem_t s4;
	gf_elem_t [`BCH_T:0] sigma;
	gf_elem_t [`BCH_T:0] bpoly;
	gf_elem_t [`BCH_T:0] mul_a;
	gf_elem_t [`BCH_T:0] mul_b;
	gf_elem_t [`BCH_T:0] prod;
	gf_elem_t [`BCH_T:0] dxb;
	gf_elem_t disc_sum;
	gf_elem_t gamma;
	gf_elem_t delta;
	logic [2:0] degree;
	logic [1:0] iter;

	// even syndromes of a binary code are squares of lower ones
	assign s2 = gf_mul(syn_q.s1, syn_q.s1);
	assign s4 = gf_mul(s2, s2);

	assign busy = (state != ks_idle);
	assign result = '{sigma: sigma, count: degree[1:0], msg: syn_q.msg};

	// multiplier bank: sigma*S when finding the discrepancy, gamma*sigma when updating
	always_comb begin
		if (state == ks_update) begin
			mul_a = {(`BCH_T+1){gamma}};
			mul_b = sigma;
		end else begin
			mul_a = sigma;
			case (iter)
				2'd0: mul_b = {{`BCH_T{zero}}, syn_q.s1};
				2'd1: mul_b = {zero, syn_q.s1, s2, syn_q.s3};
				default: mul_b = {s2, syn_q.s3, s4, syn_q.s5};
			endcase
		end
		disc_sum = zero;
		dxb[0] = zero;
		for (int i = 0; i <= `BCH_T; i++) begin
			prod[i] = gf_mul(mul_a[i], mul_b[i]);
			disc_sum = disc_sum ^ prod[i];
		end
		for (int i = 1; i <= `BCH_T; i++)
			dxb[i] = gf_mul(delta, bpoly[i-1]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ks_idle;
			iter <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ks_idle: begin
					iter <= '0;
					if (start)
						state <= ks_discrepancy;
				end
				ks_discrepancy: state <= ks_update;
				ks_update: begin
					iter <= iter + 1'b1;
					state <= (iter == `BCH_T - 1) ? ks_done : ks_discrepancy;
				end
				ks_done: begin
					if (!next_busy) begin
						done <= 1'b1;
						state <= ks_idle;
					end
				end
				default: state <= ks_idle;
			endcase
		end
	end

	// inversionless update, the skipped even step folds into x^2 on B(x)
	always_ff @(posedge clk) begin
		if (state == ks_idle && start) begin
			syn_q <= syn;
			sigma <= {{`BCH_T{zero}}, one};
			bpoly <= {{`BCH_T{zero}}, one};
			gamma <= one;
			degree <= '0;
		end else if (state == ks_discrepancy) begin
			delta <= disc_sum;
		end else if (state == ks_update) begin
			sigma <= prod ^ dxb;
			if (delta != zero && degree <= iter) begin
				bpoly <= {sigma[`BCH_T-1:0], zero};
				degree <= {iter, 1'b1} - degree;
				gamma <= delta;
			end else begin
				bpoly <= {bpoly[`BCH_T-2:0], zero, zero};
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bch_loopback.sv
`default_nettype none

`include "bch_params.svh"

module bch_loopback (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire logic [`BCH_K-1:0] data_in,
	input wire logic [`BCH_N-1:0] error,
	output logic ack,
	output logic [`BCH_K-1:0] data_out,
	output logic [1:0] err_count,
	output logic out_valid,
	output logic wrong
);

	import bch_pkg::*;

	logic enc_start;
	logic [`BCH_K-1:0] enc_data;
	logic enc_busy;
	logic code_bit;
	logic code_valid;
	logic rx_bit;
	logic rx_valid;
	logic syn_done;
	logic key_busy;
	logic key_done;
	logic err_busy;
	syn_result_t syn_result;
	key_result_t key_result;

	bch_channel_monitor u_monitor (
		.clk(clk),
		.reset(reset),
		.req(req),
		.data_in(data_in),
		.error(error),
		.enc_busy(enc_busy),
		.code_bit(code_bit),
		.code_valid(code_valid),
		.key_done(key_done),
		.key_count(key_result.count),
		.out_valid(out_valid),
		.data_out(data_out),
		.ack(ack),
		.enc_start(enc_start),
		.enc_data(enc_data),
		.rx_bit(rx_bit),
		.rx_valid(rx_valid),
		.wrong(wrong)
	);

	bch_encode u_encode (
		.clk(clk),
		.reset(reset),
		.start(enc_start),
		.data(enc_data),
		.busy(enc_busy),
		.code_bit(code_bit),
		.code_valid(code_valid)
	);

	bch_syndrome u_syndrome (
		.clk(clk),
		.reset(reset),
		.rx_bit(rx_bit),
		.rx_valid(rx_valid),
		.next_busy(key_busy),
		.busy(),
		.done(syn_done),
		.result(syn_result)
	);

	bch_key u_key (
		.clk(clk),
		.reset(reset),
		.start(syn_done),
		.syn(syn_result),
		.next_busy(err_busy),
		.busy(key_busy),
		.done(key_done),
		.result(key_result)
	);

	bch_error u_error (
		.clk(clk),
		.reset(reset),
		.start(key_done),
		.key(key_result),
		.busy(err_busy),
		.data_out(data_out),
		.err_count(err_count),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

//--- hdl/bch_pkg.sv
`default_nettype none

`include "bch_params.svh"

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s3;
		gf_elem_t s5;
		logic [`BCH_K-1:0] msg;
	} syn_result_t;

	typedef struct packed {
		gf_elem_t [`BCH_T:0] sigma;
		logic [$clog2(`BCH_T+1)-1:0] count;
		logic [`BCH_K-1:0] msg;
	} key_result_t;

	typedef enum logic [1:0] {es_idle, es_message, es_parity} enc_state_t;
	typedef enum logic [1:0] {ks_idle, ks_discrepancy, ks_update, ks_done} key_state_t;
	typedef enum logic {cs_idle, cs_search} chien_state_t;

	// polynomial basis product, reduced by the field polynomial
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		logic [2*`BCH_M-2:0] p;
		p = '0;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				p = p ^ ({{(`BCH_M-1){1'b0}}, a} << i);
		end
		for (int i = 2*`BCH_M-2; i >= `BCH_M; i--) begin
			if (p[i])
				p = p ^ ({{(`BCH_M-2){1'b0}}, `BCH_PRIM} << (i - `BCH_M));
		end
		return p[`BCH_M-1:0];
	endfunction

endpackage

`default_nettype wire

//--- hdl/bch_syndrome.sv
`default_nettype none

`include "bch_params.svh"

module bch_syndrome (
	input wire logic clk,
	input wire logic reset,
	input wire logic rx_bit,
	input wire logic rx_valid,
	input wire logic next_busy,
	output logic busy,
	output logic done,
	output bch_pkg::syn_result_t result
);

	import bch_pkg::*;

	localparam gf_elem_t alpha1 = 4'h2;
	localparam gf_elem_t alpha3 = 4'h8;
	localparam gf_elem_t alpha5 = 4'h6;

	logic [3:0] count;
	logic pending;
	logic first;
	logic last;
	gf_elem_t s1;
	gf_elem_t s3;
	gf_elem_t s5;
	gf_elem_t s1_next;
	gf_elem_t s3_next;
	gf_elem_t s5_next;
	logic [`BCH_K-1:0] msg;

	assign first = (count == 0);
	assign last = rx_valid && (count == `BCH_N - 1);
	assign busy = pending || (count != 0);

	// Horner step, the first received bit ends up with the highest power
	always_comb begin
		s1_next = (first ? gf_elem_t'(0) : gf_mul(s1, alpha1)) ^ gf_elem_t'(rx_bit);
		s3_next = (first ? gf_elem_t'(0) : gf_mul(s3, alpha3)) ^ gf_elem_t'(rx_bit);
		s5_next = (first ? gf_elem_t'(0) : gf_mul(s5, alpha5)) ^ gf_elem_t'(rx_bit);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			pending <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (rx_valid)
				count <= last ? '0 : count + 1'b1;
			if (last && next_busy) begin
				pending <= 1'b1;
			end else if ((last || pending) && !next_busy) begin
				pending <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			s1 <= s1_next;
			s3 <= s3_next;
			s5 <= s5_next;
			if (count < `BCH_K)
				msg <= {rx_bit, msg[`BCH_K-1:1]};
		end
		if (last)
			result <= '{s1: s1_next, s3: s3_next, s5: s5_next, msg: msg};
	end

endmodule

`default_nettype wire

//--- include/bch_params.svh
`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

// BCH(15,5), corrects up to three errors
`define BCH_N 15
`define BCH_K 5
`define BCH_T 3

// GF(16) element width
`define BCH_M 4

// field polynomial x^4 + x + 1
`define BCH_PRIM 5'b10011

// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
`define BCH_GEN 11'b10100110111

// transactions tracked by the channel monitor
`define BCH_TRACK_DEPTH 4

`endif

//--- list.f
+incdir+include
hdl/bch_pkg.sv
hdl/bch_encode.sv
hdl/bch_syndrome.sv
hdl/bch_key.sv
hdl/bch_error.sv
hdl/bch_channel_monitor.sv
hdl/bch_loopback.sv
test/bch_loopback_chk.sv
test/bch_loopback_tb.sv

//--- test/bch_loopback_chk.sv
`default_nettype none

module bch_loopback_chk (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire logic ack,
	input wire logic out_valid,
	input wire logic wrong
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
		else begin
			$error("ack rose without req");
			failures++;
		end

	ack_holds: assert property (@(posedge clk) disable iff (reset) (ack && req) |=> ack)
		else begin
			$error("ack fell while req was high");
			failures++;
		end

	valid_single: assert property (@(posedge clk) disable iff (reset) out_valid |=> !out_valid)
		else begin
			$error("out_valid lasted more than one cycle");
			failures++;
		end

	// sticky until reset
	wrong_sticky: assert property (@(posedge clk) (!reset && wrong) |=> wrong)
		else begin
			$error("wrong fell without reset");
			failures++;
		end

	idle_after_reset: assert property (@(posedge clk) reset |=> (!ack && !out_valid && !wrong))
		else begin
			$error("outputs not low after reset");
			failures++;
		end

endmodule

bind bch_loopback bch_loopback_chk u_chk (.*);

`default_nettype wire

//--- test/bch_loopback_tb.sv
`default_nettype none

`include "bch_params.svh"

module bch_loopback_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int handshake_limit = 200;
	localparam int drain_limit = 600;
	localparam int random_count = 40;

	typedef struct packed {
		logic [15:0] id;
		logic [`BCH_K-1:0] data;
		logic [`BCH_N-1:0] error;
		logic [3:0] count;
		logic wrong;
	} expect_t;

	logic clk;
	logic reset;
	logic req;
	logic [`BCH_K-1:0] data_in;
	logic [`BCH_N-1:0] error;
	logic ack;
	logic [`BCH_K-1:0] data_out;
	logic [1:0] err_count;
	logic out_valid;
	logic wrong;

	expect_t expected_q[$];
	integer seed;
	int test_id;
	int passed;
	int failed;

	bch_loopback u_dut (
		.clk(clk),
		.reset(reset),
		.req(req),
		.data_in(data_in),
		.error(error),
		.ack(ack),
		.data_out(data_out),
		.err_count(err_count),
		.out_valid(out_valid),
		.wrong(wrong)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int ones_in(input logic [`BCH_N-1:0] v);
		int n;
		n = 0;
		for (int i = 0; i < `BCH_N; i++)
			n += v[i];
		return n;
	endfunction

	task automatic abort_run(input string reason);
		$display("timeout: %s", reason);
		$display("Regression failed");
		$finish;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level && n < handshake_limit) begin
			@(negedge clk);
			n++;
		end
		if (ack !== level)
			abort_run(level ? "ack never rose after req" : "ack never fell after req dropped");
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (expected_q.size() != 0 && n < drain_limit) begin
			@(negedge clk);
			n++;
		end
		if (expected_q.size() != 0)
			abort_run("out_valid missing for outstanding transactions");
	endtask

	// four-phase handshake, req rises again as soon as ack is low
	task automatic send(input logic [`BCH_K-1:0] d, input logic [`BCH_N-1:0] e,
			input logic [`BCH_K-1:0] xd, input logic [3:0] xc, input logic xw);
		test_id++;
		expected_q.push_back('{id: test_id[15:0], data: xd, error: e, count: xc, wrong: xw});
		data_in = d;
		error = e;
		req = 1'b1;
		wait_ack(1'b1);
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic reset_dut();
		logic ok;
		reset = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		ok = 1'b1;
		test_id++;
		if (ack !== 1'b0) begin
			$display("FAIL ack: got 0x%h expected 0x0", ack);
			ok = 1'b0;
		end
		if (out_valid !== 1'b0) begin
			$display("FAIL out_valid: got 0x%h expected 0x0", out_valid);
			ok = 1'b0;
		end
		if (wrong !== 1'b0) begin
			$display("FAIL wrong: got 0x%h expected 0x0", wrong);
			ok = 1'b0;
		end
		if (ok)
			passed++;
		else
			failed++;
		$display("test %0d: outputs after reset %s", test_id, ok ? "ok" : "mismatch");
	endtask

	// results come back in issue order
	always @(negedge clk) begin : check_results
		expect_t x;
		logic ok;
		if (!reset && out_valid) begin
			if (expected_q.size() == 0) begin
				$display("out_valid pulsed with no transaction outstanding");
				failed++;
			end else begin
				x = expected_q.pop_front();
				ok = 1'b1;
				if (x.count <= `BCH_T) begin
					if (data_out !== x.data) begin
						$display("FAIL data_out: got 0x%h expected 0x%h", data_out, x.data);
						ok = 1'b0;
					end
					if (err_count !== x.count[1:0]) begin
						$display("FAIL err_count: got 0x%h expected 0x%h", err_count,
							x.count[1:0]);
						ok = 1'b0;
					end
				end
				if (wrong !== x.wrong) begin
					$display("FAIL wrong: got 0x%h expected 0x%h", wrong, x.wrong);
					ok = 1'b0;
				end
				if (ok)
					passed++;
				else
					failed++;
				$display("test %0d: message 0x%h pattern 0x%h %s", x.id, x.data, x.error,
					ok ? "ok" : "mismatch");
			end
		end
	end

	initial begin
		int fd;
		int code;
		string line;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] xd;
		logic [31:0] xc;
		logic [31:0] xw;
		logic [`BCH_K-1:0] msg;
		logic [`BCH_N-1:0] pat;
		int w;

		req = 1'b0;
		data_in = '0;
		error = '0;
		reset = 1'b1;
		seed = 32'h82b082b7;
		test_id = 0;
		passed = 0;
		failed = 0;
		reset_dut();

		fd = $fopen("test/bch_stimulus.dat", "r");
		if (fd == 0) begin
			$display("could not open test/bch_stimulus.dat");
			failed++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code != 0 && $sscanf(line, "%h %h %h %h %h", d, e, xd, xc, xw) == 5)
					send(d[`BCH_K-1:0], e[`BCH_N-1:0], xd[`BCH_K-1:0], xc[3:0], xw[0]);
			end
			$fclose(fd);
		end
		wait_drain();

		// wrong must clear only through reset
		reset_dut();

		for (int k = 0; k < random_count; k++) begin
			msg = $random(seed);
			w = $unsigned($random(seed)) % (`BCH_T + 1);
			pat = '0;
			while (ones_in(pat) < w)
				pat[$unsigned($random(seed)) % `BCH_N] = 1'b1;
			send(msg, pat, msg, 4'(w), 1'b0);
		end
		wait_drain();
		repeat (4) @(negedge clk);

		$display("%0d tests, %0d passed, %0d failed, %0d assertion failures", passed + failed,
			passed, failed, u_dut.u_chk.failures);
		if (failed == 0 && u_dut.u_chk.failures == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/bch_stimulus.dat
# message error_pattern expected_message expected_count expected_wrong, all in hex
# an expected count above 3 marks an uncorrectable pattern, only wrong is compared
15 0000 15 0 0
00 0000 00 0 0
1f 0001 1f 1 0
0a 4000 0a 1 0
13 0022 13 2 0
06 0300 06 2 0
1c 0018 1c 2 0
09 0007 09 3 0
11 2410 11 3 0
1e 7000 1e 3 0
05 0840 05 2 0
0b 000f 0b 4 1
17 0000 17 0 1
02 0101 02 2 1
0e 7c00 0e 5 1
1d 1000 1d 1 1
